/* bus_decoder.sv */
/*
 * address decoder
 * turns stb into one target select, muxes the replies, answers unmapped addresses
 */

`timescale 1ns/1ns

module bus_decoder (
  input  logic              clk,
  input  logic              rst_n,
  input  eco_pkg::bus_req_t req,            // master request
  output logic              sel_ram,        // ram strobe
  output logic              sel_tmr0,       // timer 0 strobe
  output logic              sel_tmr1,       // timer 1 strobe
  input  eco_pkg::bus_rsp_t ram_rsp,
  input  eco_pkg::bus_rsp_t tmr0_rsp,
  input  eco_pkg::bus_rsp_t tmr1_rsp,
  output eco_pkg::bus_rsp_t rsp             // reply to master
);

  eco_pkg::region_e region;                 // target of req.addr
  logic             err_ack;                // ack for unmapped accesses

  // ----------------------------------------
  // address classification
  // ----------------------------------------

  always_comb begin
    region = eco_pkg::REG_NONE;             // rom, dsp, kbd, ser all land here
    if (req.addr[31:eco_pkg::RAM_ADDR_BITS+2] == eco_pkg::RAM_BASE_HI) begin
      region = eco_pkg::REG_RAM;
    end else if (req.addr[31:28] == eco_pkg::IO_PAGE &&
                 req.addr[27:20] == 8'h00) begin
      // timer group, page picks the unit
      if (req.addr[19:12] == eco_pkg::TMR0_PAGE) begin
        region = eco_pkg::REG_TMR0;
      end else if (req.addr[19:12] == eco_pkg::TMR1_PAGE) begin
        region = eco_pkg::REG_TMR1;
      end
    end
  end

  // at most one of these can be high
  assign sel_ram  = req.stb && (region == eco_pkg::REG_RAM);
  assign sel_tmr0 = req.stb && (region == eco_pkg::REG_TMR0);
  assign sel_tmr1 = req.stb && (region == eco_pkg::REG_TMR1);

  // ----------------------------------------
  // unmapped access terminator
  // ----------------------------------------

  // same one-cycle timing as a real target
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_ack <= 1'b0;
    end else begin
      err_ack <= req.stb && (region == eco_pkg::REG_NONE) && !err_ack;
    end
  end

  // ----------------------------------------
  // response mux
  // ----------------------------------------

  always_comb begin
    case (region)
      eco_pkg::REG_RAM:  rsp = ram_rsp;
      eco_pkg::REG_TMR0: rsp = tmr0_rsp;
      eco_pkg::REG_TMR1: rsp = tmr1_rsp;
      default: begin
        rsp.ack   = err_ack;
        rsp.rdata = '0;                     // stray reads return zero
      end
    endcase
  end

endmodule

/* clk_rst.sv */
/*
 * clock and reset block
 * passes the clock on, reset asserts at once and releases on the clock
 */

`timescale 1ns/1ns

module clk_rst (
  input  logic clk_in,                      // board clock
  input  logic rst_n,                       // asynchronous reset, active low
  output logic clk,                         // system clock
  output logic rst_sync_n                   // reset released in step with clk
);

  logic [1:0] sync_q;                       // two-flop release chain

  assign clk = clk_in;

  // async assert, release after the second edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};          // shift in the released level
    end
  end

  assign rst_sync_n = sync_q[1];

endmodule

/* eco_bus.sv */
/*
 * eco bus subsystem top
 * reset sync, decoder, ram and two timers behind one strobe/ack bus
 */

`timescale 1ns/1ns

module eco_bus (
  input  logic                          clk_in,   // clock input
  input  logic                          rst_n,    // reset input
  input  eco_pkg::bus_req_t             req,      // from bus master
  output eco_pkg::bus_rsp_t             rsp,      // to bus master
  output logic [eco_pkg::IRQ_WIDTH-1:0] irq       // interrupt vector
);

  logic              clk;                   // system clock
  logic              rst_sync_n;            // synchronized reset
  logic              sel_ram;
  logic              sel_tmr0;
  logic              sel_tmr1;
  eco_pkg::bus_rsp_t ram_rsp;
  eco_pkg::bus_rsp_t tmr0_rsp;
  eco_pkg::bus_rsp_t tmr1_rsp;
  logic              tmr0_irq;
  logic              tmr1_irq;

  // ----------------------------------------
  // blocks
  // ----------------------------------------

  clk_rst clk_rst_1 (
    .clk_in     (clk_in),
    .rst_n      (rst_n),
    .clk        (clk),
    .rst_sync_n (rst_sync_n)
  );

  bus_decoder bus_decoder_1 (
    .clk      (clk),
    .rst_n    (rst_sync_n),
    .req      (req),
    .sel_ram  (sel_ram),
    .sel_tmr0 (sel_tmr0),
    .sel_tmr1 (sel_tmr1),
    .ram_rsp  (ram_rsp),
    .tmr0_rsp (tmr0_rsp),
    .tmr1_rsp (tmr1_rsp),
    .rsp      (rsp)
  );

  ram ram_1 (.clk(clk), .rst_n(rst_sync_n), .sel(sel_ram), .req(req), .rsp(ram_rsp));

  // timer 0 and timer 1, same block
  tmr tmr_1 (
    .clk(clk), .rst_n(rst_sync_n), .sel(sel_tmr0), .req(req), .rsp(tmr0_rsp), .irq(tmr0_irq)
  );
  tmr tmr_2 (
    .clk(clk), .rst_n(rst_sync_n), .sel(sel_tmr1), .req(req), .rsp(tmr1_rsp), .irq(tmr1_irq)
  );

  // ----------------------------------------
  // interrupt vector
  // ----------------------------------------

  always_comb begin
    irq                    = '0;            // kbd, ser lines not built
    irq[eco_pkg::TMR0_IRQ] = tmr0_irq;
    irq[eco_pkg::TMR1_IRQ] = tmr1_irq;
  end

endmodule

/* eco_bus_checker.sv */
/*
 * bus decoder checker
 * handshake and decode assertions, bound into bus_decoder
 */

`timescale 1ns/1ns

module eco_bus_checker (
  input logic              clk,
  input logic              rst_n,
  input eco_pkg::bus_req_t req,
  input logic              sel_ram,
  input logic              sel_tmr0,
  input logic              sel_tmr1,
  input eco_pkg::bus_rsp_t rsp
);

  // one target at a time
  assert property (@(posedge clk) $onehot0({sel_ram, sel_tmr0, sel_tmr1}))
    else $error("more than one target select high");

  // ack only answers a strobe from the cycle before
  assert property (@(posedge clk) disable iff (!rst_n) rsp.ack |-> $past(req.stb))
    else $error("ack without a strobe in the previous cycle");

  assert property (@(posedge clk) disable iff (!rst_n) rsp.ack |=> !rsp.ack)
    else $error("ack high for two cycles in a row");

  assert property (@(posedge clk) !rst_n |-> !rsp.ack)
    else $error("ack high during reset");

endmodule

bind bus_decoder eco_bus_checker chk_i (.*);

/* eco_bus_tb.sv */
/*
 * eco bus testbench
 * bus master tasks, per-cycle reference model, compare process and timeout
 */

`timescale 1ns/1ns

module eco_bus_tb;

  localparam int CYCLE_LIMIT = 4000;        // ~1200 for ram, ~400 timers

  logic                          clk;
  logic                          rst_n;
  eco_pkg::bus_req_t             req;
  eco_pkg::bus_rsp_t             rsp;
  logic [eco_pkg::IRQ_WIDTH-1:0] irq;

  logic [31:0] lfsr_q;
  int          err_data;                    // wrong read data or irq
  int          err_time;                    // ack not one cycle after stb
  int          err_other;
  int          cycles;

  // reference model state
  logic [31:0] shadow [1024];
  logic        busy;                        // acceptance on previous edge
  logic        pend_valid;
  logic        pend_we;
  logic [31:0] pend_addr;
  logic [31:0] pend_data;
  logic        t_en  [2];
  logic        t_ien [2];
  logic        t_exp [2];
  logic [31:0] t_div [2];
  logic [31:0] t_cnt [2];

  eco_bus dut_i (.clk_in(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .irq(irq));

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // random numbers
  // ----------------------------------------

  function logic [31:0] lfsr_step(input logic [31:0] x);
    return {x[30:0], x[31] ^ x[21] ^ x[1] ^ x[0]};   // taps 32 22 2 1
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};             // one step per bit
    end
    return v;
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // 0 none, 1 ram, 2 tmr0, 3 tmr1
  function int region_of(input logic [31:0] a);
    if (a[31:12] == 20'h0) return 1;
    if (a[31:28] == eco_pkg::IO_PAGE && a[27:20] == 8'h00) begin
      if (a[19:12] == eco_pkg::TMR0_PAGE) return 2;
      if (a[19:12] == eco_pkg::TMR1_PAGE) return 3;
    end
    return 0;
  endfunction

  function logic [31:0] ref_read(input logic [31:0] a);
    int r;
    int t;
    r = region_of(a);
    if (r == 1) return shadow[a[11:2]];
    if (r == 0) return 32'h0;               // unmapped reads give zero
    t = r - 2;
    case (a[3:2])
      2'd0:    return {29'h0, t_exp[t], t_ien[t], t_en[t]};
      2'd1:    return t_div[t];
      2'd2:    return t_cnt[t];
      default: return 32'h0;
    endcase
  endfunction

  always @(posedge clk) begin
    int r;
    if (!rst_n) begin
      busy = 1'b0;
      pend_valid = 1'b0;
      for (int t = 0; t < 2; t++) begin
        t_en[t]  = 1'b0;
        t_ien[t] = 1'b0;
        t_exp[t] = 1'b0;
        t_div[t] = '0;
        t_cnt[t] = '0;
      end
    end else begin
      pend_valid = req.stb && !busy;        // transfer accepted here
      pend_we    = req.we;
      pend_addr  = {req.addr, 2'b00};
      if (pend_valid && !req.we) pend_data = ref_read(pend_addr);
      busy = pend_valid;
      for (int t = 0; t < 2; t++) begin
        if (t_en[t]) begin
          if (t_cnt[t] == 0) begin
            t_cnt[t] = t_div[t];            // wrap and flag
            t_exp[t] = 1'b1;
          end else begin
            t_cnt[t] = t_cnt[t] - 1;
          end
        end
      end
      r = region_of(pend_addr);
      if (pend_valid && req.we) begin
        if (r == 1) shadow[pend_addr[11:2]] = req.wdata;
        if (r >= 2 && pend_addr[3:2] == 2'd0) begin
          t_en[r-2]  = req.wdata[eco_pkg::CTRL_EN];
          t_ien[r-2] = req.wdata[eco_pkg::CTRL_IEN];
          t_exp[r-2] = 1'b0;
        end
        if (r >= 2 && pend_addr[3:2] == 2'd1) begin
          t_div[r-2] = req.wdata;
          t_cnt[r-2] = req.wdata;
        end
      end
    end
  end

  // ----------------------------------------
  // compare, mid-cycle where outputs are stable
  // ----------------------------------------

  always @(negedge clk) begin
    logic [eco_pkg::IRQ_WIDTH-1:0] exp_irq;
    exp_irq = '0;
    exp_irq[eco_pkg::TMR0_IRQ] = t_exp[0] && t_ien[0];
    exp_irq[eco_pkg::TMR1_IRQ] = t_exp[1] && t_ien[1];
    if (irq !== exp_irq) begin
      err_data++;
      $display("ERR %0t irq expected %h actual %h", $time, exp_irq, irq);
    end
    if (rsp.ack && !pend_valid) begin
      err_other++;
      $display("ack seen with no transfer accepted at %0t", $time);
    end else if (rsp.ack && !pend_we && rsp.rdata !== pend_data) begin
      err_data++;
      $display("ERR %0t addr %h expected %h actual %h", $time, pend_addr, pend_data,
               rsp.rdata);
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("test timed out after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // bus master
  // ----------------------------------------

  task bus_xfer(input logic we, input logic [31:0] a, input logic [31:0] d,
                output logic [31:0] rd);
    int n;
    req.stb = 1'b1;
    req.we = we;
    req.addr = a[31:2];
    req.wdata = d;
    n = 0;
    do begin
      @(posedge clk);                       // count edges since stb
      n++;
      @(negedge clk);
    end while (!rsp.ack);
    if (n != 1) begin
      err_time++;
      $display("ERR %0t addr %h ack expected after 1 cycle actual %0d", $time, a, n);
    end
    rd = rsp.rdata;
    @(posedge clk);
    #2 req.stb = 1'b0;
    @(posedge clk);                         // one idle cycle
    #2;
  endtask

  task bus_write(input logic [31:0] a, input logic [31:0] d);
    logic [31:0] dummy;
    bus_xfer(1'b1, a, d, dummy);
  endtask

  task bus_read(input logic [31:0] a, output logic [31:0] rd);
    bus_xfer(1'b0, a, 32'h0, rd);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    logic [31:0] v;
    logic [31:0] rd;
    logic [9:0]  idx [200];
    logic        seen;
    err_data = 0;
    err_time = 0;
    err_other = 0;
    cycles = 0;
    lfsr_q = 32'h0d3a_0a18;
    req = '0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    repeat (3) @(posedge clk);              // sync release
    #2;
    bus_read(32'h3000_0000, rd);            // ctrl regs read zero
    bus_read(32'h3000_1000, rd);
    // ram fill and read back
    for (int i = 0; i < 200; i++) begin
      v = rand_bits(10);
      idx[i] = v[9:0];
      bus_write({20'h0, idx[i], 2'b00}, rand_bits(32));
    end
    for (int i = 0; i < 200; i++) bus_read({20'h0, idx[i], 2'b00}, rd);
    // unmapped: rom page, empty i/o page, other high space
    bus_write({20'h20000, idx[0], 2'b00}, 32'hdead_beef);
    bus_write({20'h30002, idx[1], 2'b00}, 32'h1234_5678);
    bus_read(32'h2000_0000, rd);
    bus_read(32'h3000_2000, rd);
    bus_read(32'h8000_0004, rd);
    bus_read({20'h0, idx[0], 2'b00}, rd);
    bus_read({20'h0, idx[1], 2'b00}, rd);
    // timer 0, irq masked first
    v = 4 + rand_bits(6) % 60;
    bus_write(32'h3000_0004, v);
    bus_write(32'h3000_0000, 32'h1);
    seen = 1'b0;
    for (int i = 0; i < 40 && !seen; i++) begin
      bus_read(32'h3000_0008, rd);
      bus_read(32'h3000_0000, rd);
      seen = rd[eco_pkg::CTRL_EXP];
    end
    if (!seen) begin
      err_other++;
      $display("timer 0 expired flag never set");
    end
    bus_write(32'h3000_0000, 32'h3);        // enable irq, clears expired
    repeat (70) @(posedge clk);             // irq compare runs every cycle
    #2;
    bus_write(32'h3000_0000, 32'h0);        // clear and stop timer 0
    // timer 1 on its own divisor
    v = 4 + rand_bits(6) % 60;
    bus_write(32'h3000_1004, v);
    bus_write(32'h3000_1000, 32'h3);
    bus_write(32'h3000_1008, 32'h5);        // cnt write ignored
    for (int i = 0; i < 30; i++) bus_read(32'h3000_1008, rd);
    bus_read(32'h3000_1000, rd);
    bus_read(32'h3000_0008, rd);
    $display("errors: data %0d, timing %0d, other %0d", err_data, err_time, err_other);
    if (err_data + err_time + err_other == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* eco_pkg.sv */
/*
 * eco bus shared definitions
 * bus request/response structs, address map constants, register encodings
 */

package eco_pkg;

  // ----------------------------------------
  // address map
  // ----------------------------------------

  localparam int RAM_ADDR_BITS = 10;        // 1024 words of RAM

  // upper word-address bits that select RAM, 31 down to RAM_ADDR_BITS+2
  localparam logic [29-RAM_ADDR_BITS:0] RAM_BASE_HI = '0;

  localparam logic [3:0] IO_PAGE   = 4'h3;  // top nibble of i/o space
  localparam logic [7:0] TMR0_PAGE = 8'h00; // addr[19:12] in i/o space
  localparam logic [7:0] TMR1_PAGE = 8'h01;

  // ----------------------------------------
  // interrupts
  // ----------------------------------------

  localparam int IRQ_WIDTH = 16;
  localparam int TMR0_IRQ  = 14;            // timer 0 request line
  localparam int TMR1_IRQ  = 15;            // timer 1 request line

  // timer control register bit positions
  localparam int CTRL_EN  = 0;              // counter enable
  localparam int CTRL_IEN = 1;              // interrupt enable
  localparam int CTRL_EXP = 2;              // expired flag, read only

  // ----------------------------------------
  // bus types
  // ----------------------------------------

  // master request, held until ack
  typedef struct packed {
    logic        stb;                       // strobe
    logic        we;                        // write enable
    logic [31:2] addr;                      // word address
    logic [31:0] wdata;                     // write data
  } bus_req_t;

  // target reply
  typedef struct packed {
    logic        ack;                       // one cycle per transfer
    logic [31:0] rdata;                     // valid with ack on reads
  } bus_rsp_t;

  // decoded target of the current address
  typedef enum logic [1:0] {
    REG_NONE,                               // unmapped, decoder answers
    REG_RAM,
    REG_TMR0,
    REG_TMR1
  } region_e;

  // timer register select, addr[3:2]
  typedef enum logic [1:0] {
    TMR_CTRL,
    TMR_DIV,
    TMR_CNT
  } tmr_reg_e;

endpackage

/* ram.sv */
/*
 * word RAM, 2^RAM_ADDR_BITS x 32
 * registered read data and ack, one cycle after select
 */

`timescale 1ns/1ns

module ram (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sel,            // strobe from decoder
  input  eco_pkg::bus_req_t req,            // uses we, addr, wdata
  output eco_pkg::bus_rsp_t rsp
);

  localparam int WORDS = 2 ** eco_pkg::RAM_ADDR_BITS;

  logic [31:0]                     mem [WORDS];
  logic [eco_pkg::RAM_ADDR_BITS-1:0] idx;   // word index
  logic                            acc;     // accepting edge
  logic                            ack_q;
  logic [31:0]                     rdata_q;

  assign idx = req.addr[eco_pkg::RAM_ADDR_BITS+1:2];
  assign acc = sel && !ack_q;               // not again in the ack cycle

  // storage and read port
  always_ff @(posedge clk) begin
    if (acc) begin
      if (req.we) begin
        mem[idx] <= req.wdata;
      end
      rdata_q <= mem[idx];                  // old contents
    end
  end

  // ack control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;                         // high for one cycle only
    end
  end

  assign rsp.ack   = ack_q;
  assign rsp.rdata = rdata_q;

endmodule

/* run.sh */
#!/bin/sh
# compile and run the eco bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f sources.f \
  --top-module eco_bus_tb \
  -o eco_bus_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/eco_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi

exit 0

/* sources.f */
eco_pkg.sv
clk_rst.sv
bus_decoder.sv
ram.sv
tmr.sv
eco_bus.sv
eco_bus_checker.sv
eco_bus_tb.sv

/* tmr.sv */
/*
 * interval timer
 * down counter with reload from divisor, expired flag and level interrupt
 */

`timescale 1ns/1ns

module tmr (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sel,            // strobe from decoder
  input  eco_pkg::bus_req_t req,            // uses we, addr[3:2], wdata
  output eco_pkg::bus_rsp_t rsp,
  output logic              irq             // level request
);

  eco_pkg::tmr_reg_e rsel;                  // addressed register
  logic              acc;                   // accepting edge
  logic              wr;                    // write on this edge
  logic              ack_q;
  logic [31:0]       rdata_q;
  logic              en_q;                  // counting enabled
  logic              ien_q;                 // interrupt enabled
  logic              exp_q;                 // counter wrapped
  logic [31:0]       div_q;                 // reload value
  logic [31:0]       cnt_q;                 // current count
  logic [31:0]       ctrl_word;
  logic [31:0]       rd_word;               // read mux

  assign rsel = eco_pkg::tmr_reg_e'(req.addr[3:2]);
  assign acc  = sel && !ack_q;
  assign wr   = acc && req.we;

  // ----------------------------------------
  // read mux
  // ----------------------------------------

  always_comb begin
    ctrl_word                   = '0;
    ctrl_word[eco_pkg::CTRL_EN]  = en_q;
    ctrl_word[eco_pkg::CTRL_IEN] = ien_q;
    ctrl_word[eco_pkg::CTRL_EXP] = exp_q;
    case (rsel)
      eco_pkg::TMR_CTRL: rd_word = ctrl_word;
      eco_pkg::TMR_DIV:  rd_word = div_q;
      eco_pkg::TMR_CNT:  rd_word = cnt_q;
      default:           rd_word = '0;      // hole at addr 3
    endcase
  end

  always_ff @(posedge clk) begin
    if (acc) rdata_q <= rd_word;            // value before this edge's update
  end

  // ----------------------------------------
  // registers and counter
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      en_q  <= 1'b0;
      ien_q <= 1'b0;
      exp_q <= 1'b0;
      div_q <= '0;
      cnt_q <= '0;
    end else begin
      ack_q <= acc;
      if (en_q) begin
        if (cnt_q == '0) begin
          cnt_q <= div_q;                   // reload
          exp_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q - 32'd1;
        end
      end
      if (wr && rsel == eco_pkg::TMR_CTRL) begin
        en_q  <= req.wdata[eco_pkg::CTRL_EN];
        ien_q <= req.wdata[eco_pkg::CTRL_IEN];
        exp_q <= 1'b0;                      // write wins over a wrap
      end
      if (wr && rsel == eco_pkg::TMR_DIV) begin
        div_q <= req.wdata;
        cnt_q <= req.wdata;                 // restart from new divisor
      end
      // cnt writes just get acked
    end
  end

  assign irq       = exp_q && ien_q;
  assign rsp.ack   = ack_q;
  assign rsp.rdata = rdata_q;

endmodule
